// ==== verilog/wasm_pkg.sv ====
// widths, header constants, section id, opcode, ALU, push source, immediate and parser state types
`default_nettype none

package wasm_pkg;

    localparam int WORD_W = 32;
    localparam int LEB_MAX_BYTES = 5;
    localparam int LEB_BITS = LEB_MAX_BYTES * 8;
    localparam int LEB_LEN_W = $clog2(LEB_MAX_BYTES + 1);

    // "\0asm" followed by version 1, byte 0 in the low bits
    localparam logic [63:0] WASM_MAGIC_VERSION = 64'h0000_0001_6d73_6100;

    localparam logic [7:0] SECTION_ID_CODE = 8'd10;

    typedef enum logic [7:0] {
        OP_NOP       = 8'h01,
        OP_END       = 8'h0b,
        OP_DROP      = 8'h1a,
        OP_SELECT    = 8'h1b,
        OP_LOCAL_GET = 8'h20,
        OP_LOCAL_SET = 8'h21,
        OP_LOCAL_TEE = 8'h22,
        OP_I32_LOAD  = 8'h28,
        OP_I32_STORE = 8'h36,
        OP_I32_CONST = 8'h41,
        OP_EQZ       = 8'h45,
        OP_EQ        = 8'h46,
        OP_NE        = 8'h47,
        OP_LT_S      = 8'h48,
        OP_LT_U      = 8'h49,
        OP_GT_S      = 8'h4a,
        OP_GT_U      = 8'h4b,
        OP_LE_S      = 8'h4c,
        OP_LE_U      = 8'h4d,
        OP_GE_S      = 8'h4e,
        OP_GE_U      = 8'h4f,
        OP_ADD       = 8'h6a,
        OP_SUB       = 8'h6b,
        OP_AND       = 8'h71,
        OP_OR        = 8'h72,
        OP_SHL       = 8'h74,
        OP_SHR_S     = 8'h75,
        OP_SHR_U     = 8'h76,
        OP_ROTL      = 8'h77,
        OP_ROTR      = 8'h78
    } opcode_e;

    // encodings follow the existing ALU
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0, ALU_SUB = 5'd1, ALU_AND_OP = 5'd2, ALU_OR_OP = 5'd3,
        ALU_SELECT = 5'd4, ALU_EQZ = 5'd5, ALU_EQ = 5'd6,
        ALU_LT_U = 5'd7, ALU_GT_U = 5'd8, ALU_LE_U = 5'd9, ALU_GE_U = 5'd10,
        ALU_LT_S = 5'd11, ALU_GT_S = 5'd12, ALU_LE_S = 5'd13, ALU_GE_S = 5'd14,
        ALU_NE = 5'd15,
        ALU_SHL = 5'd16, ALU_SHR_S = 5'd17, ALU_SHR_U = 5'd18,
        ALU_ROTL = 5'd19, ALU_ROTR = 5'd20
    } alu_op_e;

    typedef enum logic [1:0] {
        PUSH_ALU       = 2'd0,
        PUSH_MEMORY    = 2'd1,
        PUSH_IMMEDIATE = 2'd2,
        PUSH_LOCAL     = 2'd3
    } push_src_e;

    typedef enum logic [1:0] {
        IMM_NONE   = 2'd0,
        IMM_LEB    = 2'd1, // leb at byte 1
        IMM_MEMARG = 2'd2  // align at byte 1, offset leb at byte 2
    } imm_kind_e;

    typedef enum logic [2:0] {
        ST_MODULE_HEAD  = 3'd0,
        ST_SECTION_HEAD = 3'd1,
        ST_SECTION_SKIP = 3'd2,
        ST_CODE_HEAD    = 3'd3,
        ST_FUNC_HEAD    = 3'd4,
        ST_FUNC_BODY    = 3'd5,
        ST_HALTED       = 3'd6
    } parse_state_e;

endpackage

`default_nettype wire

// ==== verilog/wasm_decode_if.sv ====
// parser to opcode decoder link with opcode, issue, immediate kind and value
`timescale 1ns/1ps
`default_nettype none

interface wasm_decode_if;
    import wasm_pkg::*;

    opcode_e             opcode;
    logic                issue;     // body opcode accepted this cycle
    imm_kind_e           imm_kind;
    logic [WORD_W-1:0]   imm_value;
    logic                known;

    modport parser (
        output opcode,
        output issue,
        output imm_value,
        input  imm_kind,
        input  known
    );

    modport decoder (
        input  opcode,
        input  issue,
        input  imm_value,
        output imm_kind,
        output known
    );

endinterface

`default_nettype wire

// ==== verilog/leb128_decoder.sv ====
// combinational unsigned LEB128 decoder with byte count and overlong flag
`timescale 1ns/1ps
`default_nettype none

module leb128_decoder (
    input  wire logic [wasm_pkg::LEB_BITS-1:0]  bytes,
    output logic      [wasm_pkg::WORD_W-1:0]    value,
    output logic      [wasm_pkg::LEB_LEN_W-1:0] length,
    output logic                                overlong
);
    import wasm_pkg::*;

    logic [7*LEB_MAX_BYTES-1:0] groups; // 7-bit payloads packed in order

    always_comb begin
        length   = LEB_LEN_W'(LEB_MAX_BYTES);
        overlong = 1'b1;
        // walk downwards so the lowest terminating byte wins
        for (int i = LEB_MAX_BYTES - 1; i >= 0; i--) begin
            if (!bytes[8*i+7]) begin
                length   = LEB_LEN_W'(i + 1);
                overlong = 1'b0;
            end
        end
    end

    always_comb begin
        groups = '0;
        for (int i = 0; i < LEB_MAX_BYTES; i++) begin
            if (i < int'(length)) begin
                groups[7*i +: 7] = bytes[8*i +: 7];
            end
        end
    end

    assign value = groups[WORD_W-1:0]; // fifth byte gives only bits 31:28

endmodule

`default_nettype wire

// ==== verilog/wasm_section_parser.sv ====
// module header, section, function and body FSM with per-cycle byte consume count
`timescale 1ns/1ps
`default_nettype none

module wasm_section_parser #(
    parameter int WINDOW_BYTES = 8
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [WINDOW_BYTES*8-1:0]           window,
    input  wire logic                                window_valid,
    input  wire logic [wasm_pkg::WORD_W-1:0]         leb_value,
    input  wire logic [wasm_pkg::LEB_LEN_W-1:0]      leb_length,
    input  wire logic                                leb_overlong,
    output logic      [wasm_pkg::LEB_BITS-1:0]       leb_bytes,
    output logic      [$clog2(WINDOW_BYTES+1)-1:0]   consume,
    output logic                                     func_end,
    output logic                                     format_error,
    wasm_decode_if.parser                            dec
);
    import wasm_pkg::*;

    localparam int CW = $clog2(WINDOW_BYTES + 1);

    parse_state_e      state;
    logic [WORD_W-1:0] skip_left;   // bytes left in a skipped section
    logic [WORD_W-1:0] func_left;   // functions left in the code section
    logic [CW-1:0]     step;
    logic [CW-1:0]     skip_step;
    logic [7:0]        local_count;
    logic              bad;
    logic              is_end;

    assign dec.opcode    = opcode_e'(window[7:0]);
    assign dec.imm_value = leb_value;
    assign is_end        = dec.opcode == OP_END;
    assign local_count   = window[8*leb_length +: 8]; // byte after the body size

    assign skip_step = (skip_left < WORD_W'(WINDOW_BYTES)) ? CW'(skip_left)
                                                           : CW'(WINDOW_BYTES);

    always_comb begin
        leb_bytes = window[0 +: LEB_BITS];
        step      = '0;
        bad       = 1'b0;
        case (state)
            ST_MODULE_HEAD: begin
                step = CW'(8);
                bad  = window[63:0] != WASM_MAGIC_VERSION;
            end
            ST_SECTION_HEAD: begin
                leb_bytes = window[8 +: LEB_BITS];
                step      = CW'(leb_length) + CW'(1);
                bad       = leb_overlong;
            end
            ST_SECTION_SKIP: begin
                step = skip_step;
            end
            ST_CODE_HEAD: begin
                step = CW'(leb_length);
                bad  = leb_overlong;
            end
            ST_FUNC_HEAD: begin
                step = CW'(leb_length) + CW'(1);
                bad  = leb_overlong || local_count != 8'd0; // no local decls supported
            end
            ST_FUNC_BODY: begin
                case (dec.imm_kind)
                    IMM_LEB: begin
                        leb_bytes = window[8 +: LEB_BITS];
                        step      = CW'(leb_length) + CW'(1);
                        bad       = leb_overlong;
                    end
                    IMM_MEMARG: begin
                        leb_bytes = window[16 +: LEB_BITS];
                        step      = CW'(leb_length) + CW'(2);
                        bad       = leb_overlong;
                    end
                    default: step = CW'(1);
                endcase
                if (!dec.known) begin
                    bad = 1'b1;
                end
            end
            default: step = '0; // halted
        endcase
    end

    assign consume   = (window_valid && !bad) ? step : '0;
    assign dec.issue = window_valid && state == ST_FUNC_BODY && !bad && !is_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_MODULE_HEAD;
            skip_left    <= '0;
            func_left    <= '0;
            func_end     <= 1'b0;
            format_error <= 1'b0;
        end else begin
            func_end <= 1'b0;
            if (window_valid && bad) begin
                state        <= ST_HALTED;
                format_error <= 1'b1;
            end else if (window_valid) begin
                case (state)
                    ST_MODULE_HEAD: state <= ST_SECTION_HEAD;
                    ST_SECTION_HEAD: begin
                        skip_left <= leb_value;
                        if (window[7:0] == SECTION_ID_CODE) begin
                            state <= ST_CODE_HEAD;
                        end else if (leb_value != '0) begin
                            state <= ST_SECTION_SKIP;
                        end
                    end
                    ST_SECTION_SKIP: begin
                        skip_left <= skip_left - WORD_W'(skip_step);
                        if (skip_left == WORD_W'(skip_step)) begin
                            state <= ST_SECTION_HEAD;
                        end
                    end
                    ST_CODE_HEAD: begin
                        func_left <= leb_value;
                        state     <= (leb_value == '0) ? ST_SECTION_HEAD : ST_FUNC_HEAD;
                    end
                    ST_FUNC_HEAD: state <= ST_FUNC_BODY;
                    ST_FUNC_BODY: begin
                        if (is_end) begin
                            func_end  <= 1'b1;
                            func_left <= func_left - 1'b1;
                            state     <= (func_left == 1) ? ST_SECTION_HEAD : ST_FUNC_HEAD;
                        end
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    a_consume_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !window_valid |-> consume == '0);

    a_consume_max: assert property (@(posedge clk) disable iff (!rst_n)
        int'(consume) <= WINDOW_BYTES);

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_HALTED |=> state == ST_HALTED);

endmodule

`default_nettype wire

// ==== verilog/wasm_opcode_decoder.sv ====
// opcode table and registered stack machine control bundle
`timescale 1ns/1ps
`default_nettype none

module wasm_opcode_decoder (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    wasm_decode_if.decoder                   dec,
    output logic                             op_valid,
    output logic      [1:0]                  pop_num,
    output logic                             push_num,
    output wasm_pkg::push_src_e              push_src,
    output wasm_pkg::alu_op_e                alu_op,
    output logic      [wasm_pkg::WORD_W-1:0] imm_value,
    output logic                             local_get,
    output logic                             local_set,
    output logic                             load_en,
    output logic                             store_en
);
    import wasm_pkg::*;

    logic [1:0] t_pop;
    logic       t_push;
    push_src_e  t_src;
    alu_op_e    t_alu;
    logic       t_lget;
    logic       t_lset;
    logic       t_load;
    logic       t_store;

    always_comb begin
        dec.known    = 1'b1;
        dec.imm_kind = IMM_NONE;
        t_pop   = 2'd0;
        t_push  = 1'b0;
        t_src   = PUSH_ALU;
        t_lget  = 1'b0;
        t_lset  = 1'b0;
        t_load  = 1'b0;
        t_store = 1'b0;
        case (dec.opcode)
            OP_NOP, OP_END: t_pop = 2'd0;
            OP_DROP: t_pop = 2'd1;
            OP_SELECT: begin
                t_pop  = 2'd3;
                t_push = 1'b1;
            end
            OP_EQZ: begin
                t_pop  = 2'd1;
                t_push = 1'b1;
            end
            OP_EQ, OP_NE, OP_LT_S, OP_LT_U, OP_GT_S, OP_GT_U, OP_LE_S, OP_LE_U,
            OP_GE_S, OP_GE_U, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SHL, OP_SHR_S,
            OP_SHR_U, OP_ROTL, OP_ROTR: begin
                t_pop  = 2'd2;
                t_push = 1'b1;
            end
            OP_I32_CONST: begin
                dec.imm_kind = IMM_LEB;
                t_push       = 1'b1;
                t_src        = PUSH_IMMEDIATE;
            end
            OP_LOCAL_GET: begin
                dec.imm_kind = IMM_LEB; // local index
                t_push       = 1'b1;
                t_src        = PUSH_LOCAL;
                t_lget       = 1'b1;
            end
            OP_LOCAL_SET: begin
                dec.imm_kind = IMM_LEB;
                t_pop        = 2'd1;
                t_lset       = 1'b1;
            end
            OP_LOCAL_TEE: begin
                dec.imm_kind = IMM_LEB; // value stays on the stack
                t_lset       = 1'b1;
            end
            OP_I32_LOAD: begin
                dec.imm_kind = IMM_MEMARG;
                t_pop        = 2'd1;
                t_push       = 1'b1;
                t_src        = PUSH_MEMORY;
                t_load       = 1'b1;
            end
            OP_I32_STORE: begin
                dec.imm_kind = IMM_MEMARG;
                t_pop        = 2'd2; // address and value
                t_store      = 1'b1;
            end
            default: dec.known = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            OP_SELECT: t_alu = ALU_SELECT;
            OP_EQZ:    t_alu = ALU_EQZ;
            OP_EQ:     t_alu = ALU_EQ;
            OP_NE:     t_alu = ALU_NE;
            OP_LT_S:   t_alu = ALU_LT_S;
            OP_LT_U:   t_alu = ALU_LT_U;
            OP_GT_S:   t_alu = ALU_GT_S;
            OP_GT_U:   t_alu = ALU_GT_U;
            OP_LE_S:   t_alu = ALU_LE_S;
            OP_LE_U:   t_alu = ALU_LE_U;
            OP_GE_S:   t_alu = ALU_GE_S;
            OP_GE_U:   t_alu = ALU_GE_U;
            OP_SUB:    t_alu = ALU_SUB;
            OP_AND:    t_alu = ALU_AND_OP;
            OP_OR:     t_alu = ALU_OR_OP;
            OP_SHL:    t_alu = ALU_SHL;
            OP_SHR_S:  t_alu = ALU_SHR_S;
            OP_SHR_U:  t_alu = ALU_SHR_U;
            OP_ROTL:   t_alu = ALU_ROTL;
            OP_ROTR:   t_alu = ALU_ROTR;
            default:   t_alu = ALU_ADD; // add also forms load/store addresses
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid  <= 1'b0;
            pop_num   <= 2'd0;
            push_num  <= 1'b0;
            push_src  <= PUSH_ALU;
            alu_op    <= ALU_ADD;
            local_get <= 1'b0;
            local_set <= 1'b0;
            load_en   <= 1'b0;
            store_en  <= 1'b0;
        end else begin
            op_valid <= dec.issue;
            if (dec.issue) begin
                pop_num   <= t_pop;
                push_num  <= t_push;
                push_src  <= t_src;
                alu_op    <= t_alu;
                local_get <= t_lget;
                local_set <= t_lset;
                load_en   <= t_load;
                store_en  <= t_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.issue) begin
            imm_value <= dec.imm_value;
        end
    end

    a_no_unknown_op: assert property (@(posedge clk) disable iff (!rst_n)
        dec.issue && !dec.known |=> !op_valid);

endmodule

`default_nettype wire

// ==== verilog/wasm_ctrl_unit.sv ====
// top level joining section parser, LEB128 decoder and opcode decoder
`timescale 1ns/1ps
`default_nettype none

module wasm_ctrl_unit #(
    parameter int WINDOW_BYTES = 8
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [WINDOW_BYTES*8-1:0]          window,
    input  wire logic                               window_valid,
    output logic      [$clog2(WINDOW_BYTES+1)-1:0]  consume,
    output logic                                    op_valid,
    output logic      [1:0]                         pop_num,
    output logic                                    push_num,
    output wasm_pkg::push_src_e                     push_src,
    output wasm_pkg::alu_op_e                       alu_op,
    output logic      [wasm_pkg::WORD_W-1:0]        imm_value,
    output logic                                    local_get,
    output logic                                    local_set,
    output logic                                    load_en,
    output logic                                    store_en,
    output logic                                    func_end,
    output logic                                    format_error
);
    import wasm_pkg::*;

    logic [LEB_BITS-1:0]  leb_bytes;
    logic [WORD_W-1:0]    leb_value;
    logic [LEB_LEN_W-1:0] leb_length;
    logic                 leb_overlong;

    wasm_decode_if dec_if ();

    wasm_section_parser #(
        .WINDOW_BYTES (WINDOW_BYTES)
    ) u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_valid (window_valid),
        .leb_value    (leb_value),
        .leb_length   (leb_length),
        .leb_overlong (leb_overlong),
        .leb_bytes    (leb_bytes),
        .consume      (consume),
        .func_end     (func_end),
        .format_error (format_error),
        .dec          (dec_if.parser)
    );

    leb128_decoder u_leb (
        .bytes    (leb_bytes),
        .value    (leb_value),
        .length   (leb_length),
        .overlong (leb_overlong)
    );

    wasm_opcode_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec_if.decoder),
        .op_valid  (op_valid),
        .pop_num   (pop_num),
        .push_num  (push_num),
        .push_src  (push_src),
        .alu_op    (alu_op),
        .imm_value (imm_value),
        .local_get (local_get),
        .local_set (local_set),
        .load_en   (load_en),
        .store_en  (store_en)
    );

endmodule

`default_nettype wire

// ==== dv/wasm_ctrl_unit_vectors.svh ====
// opcode stimulus table with immediates and expected control bundle fields
`ifndef WASM_CTRL_UNIT_VECTORS_SVH
`define WASM_CTRL_UNIT_VECTORS_SVH

typedef struct packed {
    logic [7:0]  opcode;
    logic [1:0]  kind;     // immediate kind
    logic [31:0] imm;
    logic [1:0]  pop;
    logic        push;
    logic [1:0]  src;      // checked only when push is set
    logic [4:0]  alu;      // checked only for ALU pushes
    logic [3:0]  strobes;  // local_get, local_set, load_en, store_en
} op_vec_t;

localparam int NUM_VECS = 25;

op_vec_t vecs [NUM_VECS] = '{
    '{OP_I32_CONST, IMM_LEB,    32'h0000_0005, 2'd0, 1'b1, PUSH_IMMEDIATE, ALU_ADD, 4'b0000},
    '{OP_I32_CONST, IMM_LEB,    32'h0000_012c, 2'd0, 1'b1, PUSH_IMMEDIATE, ALU_ADD, 4'b0000},
    '{OP_I32_CONST, IMM_LEB,    32'h0001_2345, 2'd0, 1'b1, PUSH_IMMEDIATE, ALU_ADD, 4'b0000},
    '{OP_I32_CONST, IMM_LEB,    32'h00ab_cdef, 2'd0, 1'b1, PUSH_IMMEDIATE, ALU_ADD, 4'b0000},
    '{OP_I32_CONST, IMM_LEB,    32'hdead_beef, 2'd0, 1'b1, PUSH_IMMEDIATE, ALU_ADD, 4'b0000},
    '{OP_LOCAL_GET, IMM_LEB,    32'd3,         2'd0, 1'b1, PUSH_LOCAL,     ALU_ADD, 4'b1000},
    '{OP_ADD,       IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,       ALU_ADD, 4'b0000},
    '{OP_SUB,       IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,       ALU_SUB, 4'b0000},
    '{OP_LOCAL_SET, IMM_LEB,    32'd7,         2'd1, 1'b0, PUSH_ALU,       ALU_ADD, 4'b0100},
    '{OP_LOCAL_TEE, IMM_LEB,    32'd200,       2'd0, 1'b0, PUSH_ALU,       ALU_ADD, 4'b0100},
    '{OP_I32_LOAD,  IMM_MEMARG, 32'd16,        2'd1, 1'b1, PUSH_MEMORY,    ALU_ADD, 4'b0010},
    '{OP_I32_STORE, IMM_MEMARG, 32'd1000,      2'd2, 1'b0, PUSH_ALU,       ALU_ADD, 4'b0001},
    '{OP_NOP,       IMM_NONE,   32'd0,         2'd0, 1'b0, PUSH_ALU,       ALU_ADD, 4'b0000},
    '{OP_DROP,      IMM_NONE,   32'd0,         2'd1, 1'b0, PUSH_ALU,       ALU_ADD, 4'b0000},
    '{OP_SELECT,    IMM_NONE,   32'd0,         2'd3, 1'b1, PUSH_ALU,    ALU_SELECT, 4'b0000},
    '{OP_EQZ,       IMM_NONE,   32'd0,         2'd1, 1'b1, PUSH_ALU,       ALU_EQZ, 4'b0000},
    '{OP_EQ,        IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,        ALU_EQ, 4'b0000},
    '{OP_NE,        IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,        ALU_NE, 4'b0000},
    '{OP_LT_S,      IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,      ALU_LT_S, 4'b0000},
    '{OP_GT_U,      IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,      ALU_GT_U, 4'b0000},
    '{OP_AND,       IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,    ALU_AND_OP, 4'b0000},
    '{OP_OR,        IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,     ALU_OR_OP, 4'b0000},
    '{OP_SHL,       IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,       ALU_SHL, 4'b0000},
    '{OP_SHR_U,     IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,     ALU_SHR_U, 4'b0000},
    '{OP_ROTR,      IMM_NONE,   32'd0,         2'd2, 1'b1, PUSH_ALU,      ALU_ROTR, 4'b0000}
};

`endif

// ==== dv/wasm_ctrl_unit_tb.sv ====
// testbench with byte stream builder, window source model, output checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module wasm_ctrl_unit_tb;
    import wasm_pkg::*;

    `include "wasm_ctrl_unit_vectors.svh"

    localparam int WINDOW_BYTES = 8;
    localparam int MAX_LEN = 256;
    localparam int SPLIT = 13; // first vector of the second function

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic [WINDOW_BYTES*8-1:0]         window;
    logic                              window_valid;
    logic [$clog2(WINDOW_BYTES+1)-1:0] consume;
    logic                              op_valid;
    logic [1:0]                        pop_num;
    logic                              push_num;
    push_src_e                         push_src;
    alu_op_e                           alu_op;
    logic [WORD_W-1:0]                 imm_value;
    logic                              local_get;
    logic                              local_set;
    logic                              load_en;
    logic                              store_en;
    logic                              func_end;
    logic                              format_error;

    logic [7:0] stream [MAX_LEN];
    logic [3:0] step_at [MAX_LEN]; // expected consume where an item starts
    int         op_at [MAX_LEN];   // vector index plus one
    logic       end_at [MAX_LEN];
    int         stream_len;
    int         ptr;
    int         errors = 0;
    int         seen = 0;
    int         prev_op;
    logic       prev_end;
    int         seed = 32'h43bc;
    longint     budget = 0;
    longint     cycles = 0;

    always #10 clk = ~clk;

    wasm_ctrl_unit #(.WINDOW_BYTES(WINDOW_BYTES)) dut (
        .clk(clk), .rst_n(rst_n), .window(window), .window_valid(window_valid),
        .consume(consume), .op_valid(op_valid), .pop_num(pop_num), .push_num(push_num),
        .push_src(push_src), .alu_op(alu_op), .imm_value(imm_value),
        .local_get(local_get), .local_set(local_set), .load_en(load_en),
        .store_en(store_en), .func_end(func_end), .format_error(format_error)
    );

    function automatic int leb_len(input logic [31:0] v);
        int n;
        n = 1;
        while (v > 32'h7f) begin
            v = v >> 7;
            n++;
        end
        return n;
    endfunction

    function automatic int op_bytes(input op_vec_t v);
        int n;
        n = (v.kind == IMM_MEMARG) ? 2 : 1;
        if (v.kind != IMM_NONE)
            n = n + leb_len(v.imm);
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic clear_stream();
        stream_len = 0;
        for (int i = 0; i < MAX_LEN; i++) begin
            stream[i]  = 8'h00;
            step_at[i] = 4'd0;
            op_at[i]   = 0;
            end_at[i]  = 1'b0;
        end
    endtask

    task automatic mark(input int step, input int op, input logic fend);
        step_at[stream_len] = 4'(step);
        op_at[stream_len]   = op;
        end_at[stream_len]  = fend;
    endtask

    task automatic put_byte(input logic [7:0] b);
        stream[stream_len] = b;
        stream_len++;
    endtask

    task automatic put_leb(input logic [31:0] v);
        for (int i = leb_len(v); i > 0; i--) begin
            put_byte({i > 1, v[6:0]});
            v = v >> 7;
        end
    endtask

    task automatic put_header(input logic [7:0] version);
        logic [7:0] head [8] = '{8'h00, 8'h61, 8'h73, 8'h6d, 8'h01, 8'h00, 8'h00, 8'h00};
        head[4] = version;
        mark(8, 0, 1'b0);
        for (int i = 0; i < 8; i++)
            put_byte(head[i]);
    endtask

    task automatic put_custom(input int size);
        mark(1 + leb_len(size), 0, 1'b0);
        put_byte(8'h00);
        put_leb(size);
        for (int i = 0; i < size; i++) begin
            if (i % WINDOW_BYTES == 0) // skip chunks are capped at one window
                mark((size - i < WINDOW_BYTES) ? size - i : WINDOW_BYTES, 0, 1'b0);
            put_byte(8'(i * 7 + 3));
        end
    endtask

    task automatic put_func(input int first, input int last, input int size);
        mark(leb_len(size) + 1, 0, 1'b0);
        put_leb(size);
        put_byte(8'h00); // no local declarations
        for (int k = first; k < last; k++) begin
            mark(op_bytes(vecs[k]), k + 1, 1'b0);
            put_byte(vecs[k].opcode);
            if (vecs[k].kind == IMM_MEMARG)
                put_byte(8'h02); // align
            if (vecs[k].kind != IMM_NONE)
                put_leb(vecs[k].imm);
        end
        mark(1, 0, 1'b1);
        put_byte(8'h0b);
    endtask

    task automatic put_code();
        int size0;
        int size1;
        int total;
        size0 = 2; // local count byte and end
        size1 = 2;
        for (int k = 0; k < NUM_VECS; k++) begin
            if (k < SPLIT)
                size0 += op_bytes(vecs[k]);
            else
                size1 += op_bytes(vecs[k]);
        end
        total = 1 + leb_len(size0) + size0 + leb_len(size1) + size1;
        mark(1 + leb_len(total), 0, 1'b0);
        put_byte(8'd10);
        put_leb(total);
        mark(1, 0, 1'b0);
        put_leb(2);
        put_func(0, SPLIT, size0);
        put_func(SPLIT, NUM_VECS, size1);
    endtask

    // one function: const 5 then the unknown opcode 0xfc
    task automatic put_bad_code();
        logic [7:0] code [9] = '{8'h0a, 8'h07, 8'h01, 8'h05, 8'h00, 8'h41, 8'h05, 8'hfc, 8'h0b};
        for (int i = 0; i < 9; i++)
            put_byte(code[i]);
    endtask

    task automatic reset_dut();
        rst_n        = 1'b0;
        window_valid = 1'b0;
        window       = '0;
        ptr          = 0;
        prev_op      = 0;
        prev_end     = 1'b0;
        budget       = budget + 40 * stream_len + 40; // reset and drain cycles
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #5;
        compare_value("{op_valid,func_end,format_error,strobes,consume}",
                      {op_valid, func_end, format_error, local_get, local_set,
                       load_en, store_en, consume}, 0);
        compare_value("parser state", dut.u_parser.state, ST_MODULE_HEAD);
    endtask

    task automatic drive_window(input logic force_valid);
        @(negedge clk);
        if (force_valid)
            window_valid = 1'b1;
        else
            window_valid = ptr < stream_len && ($random(seed) & 3) != 0;
        for (int i = 0; i < WINDOW_BYTES; i++)
            window[8*i +: 8] = (ptr + i < MAX_LEN) ? stream[ptr + i] : 8'h00;
        #5; // mid low phase, everything settled
    endtask

    task automatic check_cycle();
        op_vec_t v;
        compare_value("op_valid", op_valid, prev_op != 0);
        compare_value("func_end", func_end, prev_end);
        compare_value("format_error", format_error, 0);
        if (op_valid) begin
            if (seen >= NUM_VECS) begin
                $display("more op_valid pulses than table entries");
                errors++;
            end else begin
                v = vecs[seen];
                compare_value("pop_num", pop_num, v.pop);
                compare_value("push_num", push_num, v.push);
                if (v.push)
                    compare_value("push_src", push_src, v.src);
                if (v.push && v.src == PUSH_ALU)
                    compare_value("alu_op", alu_op, v.alu);
                if (v.kind != IMM_NONE)
                    compare_value("imm_value", imm_value, v.imm);
                compare_value("{local_get,local_set,load_en,store_en}",
                              {local_get, local_set, load_en, store_en}, v.strobes);
            end
            seen++;
        end
        if (window_valid)
            compare_value("consume", consume, step_at[ptr]);
        else
            compare_value("consume", consume, 0);
        prev_op  = window_valid ? op_at[ptr] : 0;
        prev_end = window_valid && end_at[ptr];
        ptr      = ptr + consume;
    endtask

    task automatic check_error_run(input string name);
        reset_dut();
        while (!format_error && ptr < stream_len) begin
            drive_window(1'b0);
            ptr = ptr + consume;
        end
        if (!format_error) begin
            $display("format_error did not rise for the %s stream", name);
            errors++;
        end else begin
            compare_value("op_valid", op_valid, 0); // edge that took the offending window
        end
        repeat (8) begin
            drive_window(1'b1);
            compare_value("consume", consume, 0);
            compare_value("op_valid", op_valid, 0);
            compare_value("format_error", format_error, 1);
        end
    endtask

    initial begin
        clear_stream();
        put_header(8'h01);
        put_custom(20);
        put_code();
        put_custom(11);
        reset_dut();
        while (ptr < stream_len) begin
            drive_window(1'b0);
            check_cycle();
        end
        repeat (2) begin
            drive_window(1'b0);
            check_cycle();
        end
        compare_value("op_valid count", seen, NUM_VECS);
        compare_value("read pointer", ptr, stream_len);
        compare_value("parser state", dut.u_parser.state, ST_SECTION_HEAD);

        clear_stream();
        put_header(8'h02);
        check_error_run("wrong version");
        clear_stream();
        put_header(8'h01);
        put_bad_code();
        check_error_run("unknown opcode");

        $display("errors: %0d, ops seen: %0d of %0d", errors, seen, NUM_VECS);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run took more than %0d cycles", budget);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== wasm_ctrl_unit.f ====
+incdir+dv
verilog/wasm_pkg.sv
verilog/wasm_decode_if.sv
verilog/leb128_decoder.sv
verilog/wasm_section_parser.sv
verilog/wasm_opcode_decoder.sv
verilog/wasm_ctrl_unit.sv
dv/wasm_ctrl_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log holds the pass message
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f wasm_ctrl_unit.f --top-module wasm_ctrl_unit_tb \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > "$LOG" 2>&1 \
    || { echo "build or run failed, see build.log and $LOG"; exit 1; }

cat "$LOG"

grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see $LOG"; exit 1; }
